/* sim.f */
common/cpuPkg.sv
decode/regFile.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
design/hazardUnit.sv
design/memStage.sv
design/cpu.sv
verif/cpuAssert_assert.sv
verif/cpuChecker.sv
verif/tbCpu.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - files:
      - common/cpuPkg.sv
      - decode/regFile.sv
      - fetch/fetchStage.sv
      - decode/decodeStage.sv
      - execute/executeStage.sv
      - design/hazardUnit.sv
      - design/memStage.sv
      - design/cpu.sv
  - target: test
    files:
      - verif/cpuAssert_assert.sv
      - verif/cpuChecker.sv
      - verif/tbCpu.sv

/* verif/tbCpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tbCpu;
  import cpuPkg::*;

  logic     clk;
  logic     arstN;
  word_t    instr;
  word_t    pc;
  logic     regWrEn;
  regAddr_t regWrAddr;
  word_t    regWrData;
  logic     hlt;
  logic     checkDone;
  int       mismatchCount;
  int       otherCount;
  int       doneWait;

  logic [31:0] lfsrState;
  word_t       prog [61];        // 60 random words then HLT
  word_t       modelRegs [16];
  word_t       modelMem [256];

  ////////////////////////////////////////////////////////////
  // Random program
  ////////////////////////////////////////////////////////////

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic nextLfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
  endfunction

  function automatic logic [7:0] drawBits(input int n);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[6:0], nextLfsrBit()};  // One step per bit
    end
    return val;
  endfunction

  task automatic buildProgram();
    logic [7:0] pick;
    logic [7:0] low;
    opcode_t    op;
    regAddr_t   rd;
    regAddr_t   rs;
    regAddr_t   rt;
    for (int i = 0; i < 60; i++) begin
      pick = drawBits(3);
      while (pick >= 6) begin
        pick = drawBits(3);            // Reject 6 and 7 for an even pick
      end
      case (pick)
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_XOR;
        3:       op = OP_LW;
        4:       op = OP_SW;
        default: op = OP_LLB;
      endcase
      rd = regAddr_t'(drawBits(2));    // Only r0..r3 so hazards are frequent
      if (op == OP_LLB) begin
        low = drawBits(8);
        prog[i] = {op, rd, low};
      end else if ((op == OP_LW) || (op == OP_SW)) begin
        rs = regAddr_t'(drawBits(2));
        low = drawBits(4);             // Signed offset
        prog[i] = {op, rd, rs, low[3:0]};
      end else begin
        rs = regAddr_t'(drawBits(2));
        rt = regAddr_t'(drawBits(2));
        prog[i] = {op, rd, rs, rt};
      end
    end
    prog[60] = {OP_HLT, 12'h000};
  endtask

  ////////////////////////////////////////////////////////////
  // ISA model, in program order
  ////////////////////////////////////////////////////////////

  task automatic runModel();
    word_t    w;
    opcode_t  op;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t rt;
    word_t    result;
    memAddr_t addr;
    logic     writes;
    for (int i = 0; i < 16; i++) begin
      modelRegs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      modelMem[i] = '0;
    end
    for (int i = 0; i < 60; i++) begin
      w  = prog[i];
      op = w[15:12];
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      writes = 1'b1;
      result = '0;
      addr = memAddr_t'(modelRegs[rs] + {{12{w[3]}}, w[3:0]});  // Low byte of base + off
      case (op)
        OP_ADD:  result = modelRegs[rs] + modelRegs[rt];
        OP_SUB:  result = modelRegs[rs] - modelRegs[rt];
        OP_XOR:  result = modelRegs[rs] ^ modelRegs[rt];
        OP_LLB:  result = {8'h00, w[7:0]};
        OP_LW:   result = modelMem[addr];
        default: begin
          modelMem[addr] = modelRegs[rd];  // SW stores register rd
          writes = 1'b0;
        end
      endcase
      if (writes && (rd != '0)) begin    // r0 writes vanish
        modelRegs[rd] = result;
        cpuChecker_inst.expectWrite(rd, result);
      end
    end
    cpuChecker_inst.expectHaltPc(16'd122);  // HLT sits at 120
  endtask

  ////////////////////////////////////////////////////////////
  // DUT, clock and instruction port
  ////////////////////////////////////////////////////////////

  cpu cpu_inst (
    .clk(clk), .arstN(arstN), .instr(instr), .pc(pc),
    .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData), .hlt(hlt)
  );

  cpuChecker cpuChecker_inst (
    .clk(clk), .arstN(arstN), .pc(pc), .regWrEn(regWrEn),
    .regWrAddr(regWrAddr), .regWrData(regWrData), .hlt(hlt),
    .done(checkDone), .mismatchCount(mismatchCount), .otherCount(otherCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Instruction memory outside the core
  always @(negedge clk) begin
    instr = (pc[15:1] < 61) ? prog[pc[15:1]] : {OP_HLT, 12'h000};
  end

  initial begin
    arstN = 1'b0;
    instr = {OP_HLT, 12'h000};
    lfsrState = 32'd95975;
    buildProgram();
    runModel();
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    doneWait = 0;
    while (!checkDone && (doneWait < 3000)) begin
      @(negedge clk);
      doneWait++;
    end
    if (!checkDone) begin
      $display("Checker did not finish within 3000 cycles");
    end
    $display("Summary: %0d value mismatches, %0d other failures, %0d assertion failures",
             mismatchCount, otherCount, cpu_inst.cpuAssert_inst.failCount);
    if (checkDone && (mismatchCount == 0) && (otherCount == 0) &&
        (cpu_inst.cpuAssert_inst.failCount == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/cpuChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuChecker (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::word_t    pc,
  input  logic             regWrEn,    // Retire pulse
  input  cpuPkg::regAddr_t regWrAddr,
  input  cpuPkg::word_t    regWrData,
  input  logic             hlt,
  output logic             done,
  output int               mismatchCount,
  output int               otherCount
);
  import cpuPkg::*;

  regAddr_t expAddr [128];   // Expected writes in program order
  word_t    expData [128];
  int       expCount = 0;
  int       nextIdx = 0;
  word_t    haltPc = '0;
  int       waitCycles;

  task automatic expectWrite(input regAddr_t addr, input word_t data);
    expAddr[expCount] = addr;
    expData[expCount] = data;
    expCount++;
  endtask

  task automatic expectHaltPc(input word_t value);
    haltPc = value;
  endtask

  task automatic reportValue(input string name, input word_t expVal, input word_t gotVal);
    $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expVal, gotVal);
    mismatchCount++;
  endtask

  // Retire port against the model queue
  always @(negedge clk) begin
    if (arstN && regWrEn) begin
      if (nextIdx >= expCount) begin
        $display("Register write to r%0d retired after the last expected write", regWrAddr);
        otherCount++;
      end else begin
        if (regWrAddr !== expAddr[nextIdx]) begin
          reportValue("regWrAddr", word_t'(expAddr[nextIdx]), word_t'(regWrAddr));
        end
        if (regWrData !== expData[nextIdx]) begin
          reportValue("regWrData", expData[nextIdx], regWrData);
        end
        nextIdx++;
      end
    end
  end

  initial begin
    done = 1'b0;
    mismatchCount = 0;
    otherCount = 0;
    @(negedge clk);                      // Still in reset
    if (pc !== 16'h0000) reportValue("pc", 16'h0000, pc);
    if (regWrEn !== 1'b0) reportValue("regWrEn", 16'h0000, word_t'(regWrEn));
    if (hlt !== 1'b0) reportValue("hlt", 16'h0000, word_t'(hlt));
    waitCycles = 0;
    while (!arstN && (waitCycles < 50)) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!arstN) begin
      $display("Reset was not released within 50 cycles");
      otherCount++;
    end else begin
      waitCycles = 0;
      while (!hlt && (waitCycles < 2000)) begin
        @(negedge clk);
        waitCycles++;
      end
      if (!hlt) begin
        $display("hlt did not rise within 2000 cycles");
        otherCount++;
      end else begin
        if (nextIdx != expCount) begin
          $display("hlt rose with %0d expected writes not retired", expCount - nextIdx);
          otherCount++;
        end
        repeat (8) begin                 // PC frozen past HLT
          if (pc !== haltPc) reportValue("pc", haltPc, pc);
          @(negedge clk);
        end
      end
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/cpuAssert_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuAssert (
  input logic             clk,
  input logic             arstN,
  input cpuPkg::word_t    pc,
  input logic             regWrEn,
  input cpuPkg::regAddr_t regWrAddr,
  input logic             hlt
);

  int failCount = 0;   // Failed assertions so far

  hltSticky: assert property (@(posedge clk) disable iff (!arstN) hlt |=> hlt)
    else begin
      failCount++;
      $error("hlt dropped before reset");
    end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN) !pc[0])
    else begin
      failCount++;
      $error("pc is odd: 0x%h", pc);
    end

  // r0 writes never reach the retire port
  retireNonZero: assert property (@(posedge clk) disable iff (!arstN)
    regWrEn |-> (regWrAddr != '0))
    else begin
      failCount++;
      $error("Retire pulse for r0");
    end

  quietAfterHalt: assert property (@(posedge clk) disable iff (!arstN) hlt |-> !regWrEn)
    else begin
      failCount++;
      $error("Register write while halted");
    end

endmodule

bind cpu cpuAssert cpuAssert_inst (
  .clk(clk), .arstN(arstN), .pc(pc), .regWrEn(regWrEn),
  .regWrAddr(regWrAddr), .hlt(hlt)
);

`default_nettype wire

/* design/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::word_t    instr,      // Instruction word for pc
  output cpuPkg::word_t    pc,
  output logic             regWrEn,    // Retire pulse
  output cpuPkg::regAddr_t regWrAddr,
  output cpuPkg::word_t    regWrData,
  output logic             hlt
);
  import cpuPkg::*;

  logic     stall;       // Load-use hold
  logic     haltSeen;
  word_t    ifIdInstr;
  logic     ifIdValid;
  regAddr_t idRs;
  regAddr_t idRt;
  opcode_t  exOp;
  regAddr_t exRd;
  regAddr_t exRs;
  regAddr_t exRt;
  word_t    exOpA;
  word_t    exOpB;
  word_t    exImm;
  logic     exWrites;
  logic     exIsLoad;
  logic     exHalt;
  fwdSel_t  fwdA;
  fwdSel_t  fwdB;
  word_t    memResult;
  word_t    memStoreData;
  regAddr_t memRd;
  logic     memWrites;
  logic     memIsLoad;
  logic     memIsStore;
  logic     memHalt;
  logic     wbEn;
  regAddr_t wbAddr;
  word_t    wbData;

  ////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////

  fetchStage fetchStage_inst (
    .clk(clk), .arstN(arstN), .stall(stall), .haltSeen(haltSeen),
    .instr(instr), .pc(pc), .ifIdInstr(ifIdInstr), .ifIdValid(ifIdValid)
  );

  decodeStage decodeStage_inst (
    .clk(clk), .arstN(arstN), .ifIdInstr(ifIdInstr), .ifIdValid(ifIdValid),
    .stall(stall), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
    .idRs(idRs), .idRt(idRt), .haltSeen(haltSeen),
    .exOp(exOp), .exRd(exRd), .exRs(exRs), .exRt(exRt),
    .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm),
    .exWrites(exWrites), .exIsLoad(exIsLoad), .exHalt(exHalt)
  );

  ////////////////////////////////////////////////////////////
  // Execute and hazards
  ////////////////////////////////////////////////////////////

  hazardUnit hazardUnit_inst (
    .idRs(idRs), .idRt(idRt), .exRs(exRs), .exRt(exRt), .exRd(exRd),
    .exIsLoad(exIsLoad), .memRd(memRd), .memWrites(memWrites),
    .memIsLoad(memIsLoad), .wbAddr(wbAddr), .wbEn(wbEn),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
  );

  executeStage executeStage_inst (
    .clk(clk), .arstN(arstN), .exOp(exOp), .exRd(exRd),
    .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exWrites(exWrites),
    .exIsLoad(exIsLoad), .exHalt(exHalt), .fwdA(fwdA), .fwdB(fwdB),
    .wbData(wbData), .memResult(memResult), .memStoreData(memStoreData),
    .memRd(memRd), .memWrites(memWrites), .memIsLoad(memIsLoad),
    .memIsStore(memIsStore), .memHalt(memHalt)
  );

  ////////////////////////////////////////////////////////////
  // Memory and writeback
  ////////////////////////////////////////////////////////////

  memStage memStage_inst (
    .clk(clk), .arstN(arstN), .memResult(memResult), .memStoreData(memStoreData),
    .memRd(memRd), .memWrites(memWrites), .memIsLoad(memIsLoad),
    .memIsStore(memIsStore), .exHalt(memHalt),  // Halt marker in EX/MEM
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .hlt(hlt)
  );

  // Writeback doubles as the retire port
  assign regWrEn   = wbEn;
  assign regWrAddr = wbAddr;
  assign regWrData = wbData;

endmodule

`default_nettype wire

/* design/memStage.sv */
`timescale 1ns/1ns
`default_nettype none

module memStage (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::word_t    memResult,     // ALU result or address
  input  cpuPkg::word_t    memStoreData,
  input  cpuPkg::regAddr_t memRd,
  input  logic             memWrites,
  input  logic             memIsLoad,
  input  logic             memIsStore,
  input  logic             exHalt,        // Halt marker
  output logic             wbEn,
  output cpuPkg::regAddr_t wbAddr,
  output cpuPkg::word_t    wbData,
  output logic             hlt
);
  import cpuPkg::*;

  word_t    dmem [DMEM_WORDS];
  memAddr_t dmemAddr;
  word_t    loadData;

  assign dmemAddr = memResult[7:0];
  assign loadData = dmem[dmemAddr];  // Combinational read

  // Data memory write port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (memIsStore) begin
      dmem[dmemAddr] <= memStoreData;
    end
  end

  // MEM/WB control and halt
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbEn   <= 1'b0;
      wbAddr <= '0;
      hlt    <= 1'b0;
    end else begin
      wbEn   <= memWrites;
      wbAddr <= memRd;
      hlt    <= hlt | exHalt;   // Held until reset
    end
  end

  // MEM/WB data
  always_ff @(posedge clk) begin
    wbData <= memIsLoad ? loadData : memResult;
  end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
  input  cpuPkg::regAddr_t idRs,
  input  cpuPkg::regAddr_t idRt,
  input  cpuPkg::regAddr_t exRs,
  input  cpuPkg::regAddr_t exRt,
  input  cpuPkg::regAddr_t exRd,
  input  logic             exIsLoad,
  input  cpuPkg::regAddr_t memRd,
  input  logic             memWrites,
  input  logic             memIsLoad,
  input  cpuPkg::regAddr_t wbAddr,
  input  logic             wbEn,
  output cpuPkg::fwdSel_t  fwdA,
  output cpuPkg::fwdSel_t  fwdB,
  output logic             stall
);
  import cpuPkg::*;

  logic exMemOk;   // EX/MEM holds a usable result
  logic memWbOk;

  // Load data is not ready in EX/MEM
  assign exMemOk = memWrites && !memIsLoad && (memRd != '0);
  assign memWbOk = wbEn && (wbAddr != '0);

  // Nearer producer wins
  assign fwdA = (exMemOk && (memRd == exRs)) ? FWD_EXMEM :
                (memWbOk && (wbAddr == exRs)) ? FWD_MEMWB : FWD_NONE;
  assign fwdB = (exMemOk && (memRd == exRt)) ? FWD_EXMEM :
                (memWbOk && (wbAddr == exRt)) ? FWD_MEMWB : FWD_NONE;

  // Load in EX feeding the instruction in decode
  assign stall = exIsLoad && (exRd != '0) && ((exRd == idRs) || (exRd == idRt));

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::opcode_t  exOp,
  input  cpuPkg::regAddr_t exRd,
  input  cpuPkg::word_t    exOpA,
  input  cpuPkg::word_t    exOpB,
  input  cpuPkg::word_t    exImm,
  input  logic             exWrites,
  input  logic             exIsLoad,
  input  logic             exHalt,
  input  cpuPkg::fwdSel_t  fwdA,
  input  cpuPkg::fwdSel_t  fwdB,
  input  cpuPkg::word_t    wbData,       // MEM/WB forward source
  output cpuPkg::word_t    memResult,    // Also the EX/MEM forward source
  output cpuPkg::word_t    memStoreData,
  output cpuPkg::regAddr_t memRd,
  output logic             memWrites,
  output logic             memIsLoad,
  output logic             memIsStore,
  output logic             memHalt
);
  import cpuPkg::*;

  word_t srcA;     // Base for LW/SW
  word_t srcB;     // Store data for SW
  word_t aluOut;

  function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                   input word_t exMemVal, input word_t memWbVal);
    case (sel)
      FWD_EXMEM: return exMemVal;
      FWD_MEMWB: return memWbVal;
      default:   return regVal;
    endcase
  endfunction

  assign srcA = fwdMux(fwdA, exOpA, memResult, wbData);
  assign srcB = fwdMux(fwdB, exOpB, memResult, wbData);

  // ALU and address adder
  always_comb begin
    case (exOp)
      OP_SUB:       aluOut = srcA - srcB;
      OP_XOR:       aluOut = srcA ^ srcB;
      OP_LLB:       aluOut = exImm;
      OP_LW, OP_SW: aluOut = srcA + exImm;   // Word address in low byte
      default:      aluOut = srcA + srcB;    // ADD and bubbles
    endcase
  end

  // EX/MEM control
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memRd      <= '0;
      memWrites  <= 1'b0;
      memIsLoad  <= 1'b0;
      memIsStore <= 1'b0;
      memHalt    <= 1'b0;
    end else begin
      memRd      <= exRd;
      memWrites  <= exWrites;
      memIsLoad  <= exIsLoad;
      memIsStore <= exOp == OP_SW;  // Bubbles carry OP_ADD
      memHalt    <= exHalt;
    end
  end

  // EX/MEM data
  always_ff @(posedge clk) begin
    memResult    <= aluOut;
    memStoreData <= srcB;
  end

endmodule

`default_nettype wire

/* decode/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::word_t    ifIdInstr,
  input  logic             ifIdValid,
  input  logic             stall,
  input  logic             wbEn,       // Register write from WB
  input  cpuPkg::regAddr_t wbAddr,
  input  cpuPkg::word_t    wbData,
  output cpuPkg::regAddr_t idRs,
  output cpuPkg::regAddr_t idRt,
  output logic             haltSeen,
  output cpuPkg::opcode_t  exOp,
  output cpuPkg::regAddr_t exRd,
  output cpuPkg::regAddr_t exRs,
  output cpuPkg::regAddr_t exRt,
  output cpuPkg::word_t    exOpA,
  output cpuPkg::word_t    exOpB,
  output cpuPkg::word_t    exImm,
  output logic             exWrites,
  output logic             exIsLoad,
  output logic             exHalt
);
  import cpuPkg::*;

  opcode_t  op;
  regAddr_t rd;        // Destination or store data
  regAddr_t rs;
  regAddr_t rt;
  logic     isAlu;
  logic     isLoad;
  logic     isStore;
  logic     isLlb;
  logic     isHlt;
  logic     idLive;    // Real entry for ID/EX this cycle
  logic     haltLatch;
  word_t    imm;
  word_t    rdDataA;
  word_t    rdDataB;

  // Fields
  assign op = ifIdInstr[15:12];
  assign rd = ifIdInstr[11:8];
  assign rs = ifIdInstr[7:4];
  assign rt = ifIdInstr[3:0];

  assign isAlu   = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR);
  assign isLoad  = op == OP_LW;
  assign isStore = op == OP_SW;
  assign isLlb   = op == OP_LLB;
  assign isHlt   = op == OP_HLT;

  // Unused sources read r0 so they never forward or stall
  assign idRs = (ifIdValid && (isAlu || isLoad || isStore)) ? rs : '0;
  assign idRt = !ifIdValid ? '0 : isAlu ? rt : isStore ? rd : '0;

  // LLB zero-extends while LW/SW offsets sign-extend
  assign imm = isLlb ? {8'h00, ifIdInstr[7:0]} : {{12{ifIdInstr[3]}}, ifIdInstr[3:0]};

  assign idLive   = ifIdValid && !stall;
  assign haltSeen = haltLatch || (ifIdValid && isHlt);  // Same-cycle PC freeze

  regFile regFile_inst (
    .clk(clk), .arstN(arstN), .rdAddrA(idRs), .rdAddrB(idRt),
    .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData),
    .rdDataA(rdDataA), .rdDataB(rdDataB)
  );

  // ID/EX control with a bubble on stall or empty IF/ID
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltLatch <= 1'b0;
      exOp      <= OP_ADD;
      exRd      <= '0;
      exRs      <= '0;
      exRt      <= '0;
      exWrites  <= 1'b0;
      exIsLoad  <= 1'b0;
      exHalt    <= 1'b0;
    end else begin
      haltLatch <= haltSeen;                    // Sticky until reset
      exOp      <= idLive ? op : OP_ADD;
      exRd      <= idLive ? rd : '0;
      exRs      <= idLive ? idRs : '0;
      exRt      <= idLive ? idRt : '0;
      exWrites  <= idLive && (isAlu || isLlb || isLoad) && (rd != '0);  // r0 never retires
      exIsLoad  <= idLive && isLoad;
      exHalt    <= idLive && isHlt;
    end
  end

  // ID/EX operands
  always_ff @(posedge clk) begin
    exOpA <= rdDataA;
    exOpB <= rdDataB;
    exImm <= imm;
  end

endmodule

`default_nettype wire

/* fetch/fetchStage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
  input  logic          clk,
  input  logic          arstN,
  input  logic          stall,      // Load-use hold
  input  logic          haltSeen,   // HLT in or past decode
  input  cpuPkg::word_t instr,
  output cpuPkg::word_t pc,
  output cpuPkg::word_t ifIdInstr,
  output logic          ifIdValid
);
  import cpuPkg::*;

  word_t pcPlus2;
  logic  pcHold;

  assign pcPlus2 = pc + 16'd2;     // Word-aligned step
  assign pcHold  = stall | haltSeen;

  // PC register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!pcHold) begin
      pc <= pcPlus2;
    end
  end

  // IF/ID valid
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ifIdValid <= 1'b0;
    end else if (haltSeen) begin
      ifIdValid <= 1'b0;           // Bubbles only after HLT
    end else if (!stall) begin
      ifIdValid <= 1'b1;
    end
  end

  // IF/ID word held on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      ifIdInstr <= instr;
    end
  end

endmodule

`default_nettype wire

/* decode/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::regAddr_t rdAddrA,
  input  cpuPkg::regAddr_t rdAddrB,
  input  logic             wrEn,
  input  cpuPkg::regAddr_t wrAddr,
  input  cpuPkg::word_t    wrData,
  output cpuPkg::word_t    rdDataA,
  output cpuPkg::word_t    rdDataB
);
  import cpuPkg::*;

  word_t regs [NUM_REGS];

  // Write port that leaves r0 at zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read ports with write-through bypass
  assign rdDataA = (rdAddrA == '0) ? '0 :
                   (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 :
                   (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

/* common/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // Widths that carry a meaning
  typedef logic [15:0] word_t;     // Data or instruction word
  typedef logic [3:0]  regAddr_t;  // Register index
  typedef logic [3:0]  opcode_t;   // Instruction bits [15:12]
  typedef logic [7:0]  memAddr_t;  // Data memory word address
  typedef logic [1:0]  fwdSel_t;   // EX operand source

  // Operand source codes
  localparam fwdSel_t FWD_NONE  = 2'd0;  // Value read in decode
  localparam fwdSel_t FWD_EXMEM = 2'd1;  // ALU result one ahead
  localparam fwdSel_t FWD_MEMWB = 2'd2;  // Writeback value two ahead

  // Opcodes
  localparam opcode_t OP_ADD = 4'd0;
  localparam opcode_t OP_SUB = 4'd1;
  localparam opcode_t OP_XOR = 4'd2;
  localparam opcode_t OP_LW  = 4'd8;
  localparam opcode_t OP_SW  = 4'd9;
  localparam opcode_t OP_LLB = 4'd10;
  localparam opcode_t OP_HLT = 4'd15;

  // Storage depths
  localparam int NUM_REGS   = 16;
  localparam int DMEM_WORDS = 256;

endpackage

`default_nettype wire
